/* logic/multdiv_pkg.sv */
package multdiv_pkg;

	// Operand and result width, one machine word
	localparam int operand_width = 32;

	// Full product is two words wide
	localparam int product_width = 2 * operand_width;

	// Partial-product rows handled by one pipeline stage
	localparam int rows_per_stage = 8;

	// Stages needed to consume every bit of operand B
	localparam int num_array_stages = operand_width / rows_per_stage;

	// Capture to ready, one cycle per array stage plus the output register
	localparam int mult_latency = num_array_stages + 1;

	// Operand and result word
	typedef logic [operand_width-1:0] operand_t;

	// Running accumulator for the partial products
	typedef logic [product_width-1:0] product_t;

endpackage

/* logic/operand_capture.sv */
`timescale 1ns/1ns

module operand_capture (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  ctrl_mult,
	input  multdiv_pkg::operand_t data_operand_a,
	input  multdiv_pkg::operand_t data_operand_b,
	output logic                  cap_valid,
	output multdiv_pkg::operand_t cap_a,
	output multdiv_pkg::operand_t cap_b
);

	import multdiv_pkg::*;

	// Strobe becomes the valid bit of the first pipeline link
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			cap_valid <= 1'b0;
		end else begin
			cap_valid <= ctrl_mult;
		end
	end

	// Operands are only loaded on a strobe, otherwise held
	always_ff @(posedge clock) begin
		if (ctrl_mult) begin
			cap_a <= data_operand_a;
			cap_b <= data_operand_b;
		end
	end

endmodule

/* logic/partial_product_row.sv */
`timescale 1ns/1ns

module partial_product_row (
	input  multdiv_pkg::operand_t           sum_in,
	input  multdiv_pkg::operand_t           multiplicand,
	input  logic                            multiplier_bit,
	output logic [multdiv_pkg::operand_width:0] sum_out
);

	import multdiv_pkg::*;

	// Multiplicand ANDed with the current multiplier bit
	operand_t partial;

	// Ripple carry chain, one more entry than there are adders
	logic [operand_width:0] carry;

	assign partial = multiplicand & {operand_width{multiplier_bit}};

	// No carry into the lowest adder
	assign carry[0] = 1'b0;

	genvar i;
	generate
		for (i = 0; i < operand_width; i = i + 1) begin : g_fa
			// Full adder sum
			assign sum_out[i] = sum_in[i] ^ partial[i] ^ carry[i];

			// Full adder carry, majority of the three inputs
			assign carry[i+1] = (sum_in[i] & partial[i])
				| (sum_in[i] & carry[i])
				| (partial[i] & carry[i]);
		end
	endgenerate

	// Carry out of the top adder widens the row result to 33 bits
	assign sum_out[operand_width] = carry[operand_width];

endmodule

/* logic/array_mult_stage.sv */
`timescale 1ns/1ns

module array_mult_stage #(
	parameter int first_row = 0
) (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  multdiv_pkg::operand_t in_a,
	input  multdiv_pkg::operand_t in_b,
	input  multdiv_pkg::product_t in_acc,
	output logic                  out_valid,
	output multdiv_pkg::operand_t out_a,
	output multdiv_pkg::operand_t out_b,
	output multdiv_pkg::product_t out_acc
);

	import multdiv_pkg::*;

	// Ones over the 33-bit window that one row rewrites
	localparam product_t window_mask = product_t'({(operand_width + 1){1'b1}});

	// Accumulator between rows, entry 0 is the stage input
	product_t acc_chain [rows_per_stage+1];

	assign acc_chain[0] = in_acc;

	genvar k;
	generate
		for (k = 0; k < rows_per_stage; k = k + 1) begin : g_row
			// Bit position of this row within the product
			localparam int base = first_row + k;

			logic [operand_width:0] row_sum;

			// Multiplier bits arrive shifted, so row k reads bit k
			partial_product_row u_row (
				.sum_in         (acc_chain[k][base +: operand_width]),
				.multiplicand   (in_a),
				.multiplier_bit (in_b[k]),
				.sum_out        (row_sum)
			);

			// Replace the window with the row result, keep the rest
			assign acc_chain[k+1] = (acc_chain[k] & ~(window_mask << base))
				| (product_t'(row_sum) << base);
		end
	endgenerate

	// Valid bit of the outgoing link
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// Payload moves on every edge, no stall
	always_ff @(posedge clock) begin
		out_a   <= in_a;
		out_b   <= in_b >> rows_per_stage;
		out_acc <= acc_chain[rows_per_stage];
	end

endmodule

/* logic/product_output.sv */
`timescale 1ns/1ns

module product_output (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  prod_valid,
	input  multdiv_pkg::product_t prod_acc,
	output multdiv_pkg::operand_t data_result,
	output logic                  data_exception,
	output logic                  data_result_rdy
);

	import multdiv_pkg::*;

	// Low word goes out as the result
	operand_t low_word;

	// Any bit set in the high word is unsigned overflow
	logic overflow;

	assign low_word = prod_acc[operand_width-1:0];
	assign overflow = |prod_acc[product_width-1:operand_width];

	// One-cycle ready pulse per finished product
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			data_result_rdy <= 1'b0;
		end else begin
			data_result_rdy <= prod_valid;
		end
	end

	// Result and flag hold between products
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			data_result    <= '0;
			data_exception <= 1'b0;
		end else if (prod_valid) begin
			data_result    <= low_word;
			data_exception <= overflow;
		end
	end

endmodule

/* logic/multdiv.sv */
`timescale 1ns/1ns

module multdiv (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  ctrl_mult,
	input  multdiv_pkg::operand_t data_operand_a,
	input  multdiv_pkg::operand_t data_operand_b,
	output multdiv_pkg::operand_t data_result,
	output logic                  data_exception,
	output logic                  data_result_rdy
);

	import multdiv_pkg::*;

	// Pipeline links, entry s feeds array stage s
	logic     link_valid [num_array_stages+1];
	operand_t link_a     [num_array_stages+1];
	operand_t link_b     [num_array_stages+1];
	product_t link_acc   [num_array_stages+1];

	// Input side
	operand_capture u_capture (
		.clock          (clock),
		.rst_n          (rst_n),
		.ctrl_mult      (ctrl_mult),
		.data_operand_a (data_operand_a),
		.data_operand_b (data_operand_b),
		.cap_valid      (link_valid[0]),
		.cap_a          (link_a[0]),
		.cap_b          (link_b[0])
	);

	// Accumulation starts from zero
	assign link_acc[0] = '0;

	// Four stages of eight rows, first_row at 0, 8, 16 and 24
	genvar s;
	generate
		for (s = 0; s < num_array_stages; s = s + 1) begin : g_stage
			array_mult_stage #(
				.first_row (s * rows_per_stage)
			) u_stage (
				.clock     (clock),
				.rst_n     (rst_n),
				.in_valid  (link_valid[s]),
				.in_a      (link_a[s]),
				.in_b      (link_b[s]),
				.in_acc    (link_acc[s]),
				.out_valid (link_valid[s+1]),
				.out_a     (link_a[s+1]),
				.out_b     (link_b[s+1]),
				.out_acc   (link_acc[s+1])
			);
		end
	endgenerate

	// Output side, operands of the last link are no longer needed
	product_output u_output (
		.clock           (clock),
		.rst_n           (rst_n),
		.prod_valid      (link_valid[num_array_stages]),
		.prod_acc        (link_acc[num_array_stages]),
		.data_result     (data_result),
		.data_exception  (data_exception),
		.data_result_rdy (data_result_rdy)
	);

endmodule

/* verification/multdiv_tb.sv */
`timescale 1ns/1ns

module multdiv_tb;

	import multdiv_pkg::*;

	// One record is four words: operand A, operand B, result, exception
	localparam int num_patterns = 38;
	localparam int fields = 4;
	localparam int quiet_cycles = 6;
	localparam int timeout_cycles = num_patterns * 4 + mult_latency + 20;

	logic     clock;
	logic     rst_n;
	logic     ctrl_mult;
	operand_t data_operand_a;
	operand_t data_operand_b;
	operand_t data_result;
	logic     data_exception;
	logic     data_result_rdy;

	logic [31:0] pattern_mem [num_patterns*fields];

	// Expected responses in issue order
	operand_t exp_result_q [$];
	logic     exp_exception_q [$];

	integer seed;
	int     cycle_count;
	int     strobe_count;
	int     rdy_count;
	int     result_errors;
	int     exception_errors;
	int     other_errors;

	multdiv uut (
		.clock           (clock),
		.rst_n           (rst_n),
		.ctrl_mult       (ctrl_mult),
		.data_operand_a  (data_operand_a),
		.data_operand_b  (data_operand_b),
		.data_result     (data_result),
		.data_exception  (data_exception),
		.data_result_rdy (data_result_rdy)
	);

	always #5 clock = ~clock;

	task automatic issue_operation(input int idx);
		ctrl_mult      <= 1'b1;
		data_operand_a <= pattern_mem[idx*fields];
		data_operand_b <= pattern_mem[idx*fields+1];
		exp_result_q.push_back(pattern_mem[idx*fields+2]);
		exp_exception_q.push_back(pattern_mem[idx*fields+3][0]);
		strobe_count++;
	endtask

	// Operands keep moving while the strobe is low
	task automatic drive_idle();
		ctrl_mult      <= 1'b0;
		data_operand_a <= $random(seed);
		data_operand_b <= $random(seed);
	endtask

	task automatic print_summary();
		$write("Summary: %0d strobes, %0d ready pulses, ", strobe_count, rdy_count);
		$display("%0d result errors, %0d exception errors, %0d other errors",
			result_errors, exception_errors, other_errors);
	endtask

	// Each ready pulse is matched with the oldest expected entry
	always @(negedge clock) begin
		operand_t exp_result;
		logic     exp_exception;
		if (rst_n && data_result_rdy) begin
			rdy_count++;
			if (exp_result_q.size() == 0) begin
				other_errors++;
				$display("Error at %0t: ready pulse with no operation in flight", $time);
			end else begin
				exp_result = exp_result_q.pop_front();
				exp_exception = exp_exception_q.pop_front();
				if (data_result !== exp_result) begin
					result_errors++;
					$display("Error at %0t: data_result %h, expected %h",
						$time, data_result, exp_result);
				end
				if (data_exception !== exp_exception) begin
					exception_errors++;
					$display("Error at %0t: data_exception %b, expected %b",
						$time, data_exception, exp_exception);
				end
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout after %0d cycles, results did not arrive in time", cycle_count);
			print_summary();
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		int gap;
		int i;
		clock = 1'b0;
		rst_n = 1'b0;
		ctrl_mult = 1'b0;
		data_operand_a = '0;
		data_operand_b = '0;
		seed = 32'hfe88;
		cycle_count = 0;
		strobe_count = 0;
		rdy_count = 0;
		result_errors = 0;
		exception_errors = 0;
		other_errors = 0;
		$readmemh("verification/mult_patterns.hex", pattern_mem);

		repeat (3) @(posedge clock);
		rst_n <= 1'b1;

		// Nothing may leave the pipeline before the first strobe
		repeat (quiet_cycles) begin
			@(negedge clock);
			if (data_result_rdy !== 1'b0) begin
				other_errors++;
				$display("Error at %0t: data_result_rdy high before any strobe", $time);
			end
			if (data_result !== '0) begin
				result_errors++;
				$display("Error at %0t: data_result %h before any strobe, expected 0",
					$time, data_result);
			end
		end

		for (i = 0; i < num_patterns; i++) begin
			@(posedge clock);
			issue_operation(i);
			// Middle stretch runs back to back
			if (i < 10 || i >= 24)
				gap = $unsigned($random(seed)) % 4;
			else
				gap = 0;
			repeat (gap) begin
				@(posedge clock);
				drive_idle();
			end
		end
		@(posedge clock);
		drive_idle();

		while (exp_result_q.size() != 0) @(posedge clock);
		// Extra cycles to catch stray pulses
		repeat (mult_latency) @(posedge clock);

		if (rdy_count != strobe_count) begin
			other_errors++;
			$display("Ready pulse count %0d does not match strobe count %0d",
				rdy_count, strobe_count);
		end

		print_summary();
		if (result_errors + exception_errors + other_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* verification/mult_patterns.hex */
// Columns: operand A, operand B, expected result (low 32 bits of A*B),
// expected exception (1 when the high 32 bits of A*B are not all zero)
00000000 00000000 00000000 0
00000000 ffffffff 00000000 0
ffffffff 00000000 00000000 0
00000001 00000001 00000001 0
00000001 ffffffff ffffffff 0
ffffffff 00000001 ffffffff 0
12345678 00000001 12345678 0
00000003 00000005 0000000f 0
00000007 00000009 0000003f 0
0000ffff 0000ffff fffe0001 0
00010000 0000ffff ffff0000 0
000000ff 00000100 0000ff00 0
00000064 00000064 00002710 0
0000000c 0000000d 0000009c 0
00001000 00001000 01000000 0
80000000 00000001 80000000 0
00000002 7fffffff fffffffe 0
00012345 00000010 00123450 0
000003e8 000003e8 000f4240 0
ffffffff ffffffff 00000001 1
00010000 00010000 00000000 1
80000000 00000002 00000000 1
00000002 80000000 00000000 1
80000000 80000000 00000000 1
ffffffff 00000002 fffffffe 1
00000003 80000000 80000000 1
0001ffff 00010001 0000ffff 1
12345678 00000010 23456780 1
10000000 00000010 00000000 1
00100000 00001001 00100000 1
ffffffff 00010000 ffff0000 1
87654321 00000100 65432100 1
abcdef01 00001000 def01000 1
fedcba98 00000003 fc962fc8 1
00000010 fedcba98 edcba980 1
c0000000 00000004 00000000 1
0000ffff 00010001 ffffffff 0
00010001 00010000 00010000 1

/* sources.f */
logic/multdiv_pkg.sv
logic/operand_capture.sv
logic/partial_product_row.sv
logic/array_mult_stage.sv
logic/product_output.sv
logic/multdiv.sv
verification/multdiv_tb.sv

/* Makefile */
TOP = multdiv_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf obj_dir
